/* hw/alu.sv */
`timescale 1ns/1ns

module alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    output rv_pkg::word_t   y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Shift amount from the low five bits only
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb
    begin
        case (op)
            rv_pkg::alu_add:
            begin
                y = a + b;
            end
            rv_pkg::alu_sub:
            begin
                y = a - b;
            end
            rv_pkg::alu_sll:
            begin
                y = a << shamt;
            end
            rv_pkg::alu_slt:
            begin
                y = {31'd0, lt_signed};
            end
            rv_pkg::alu_sltu:
            begin
                y = {31'd0, lt_unsigned};
            end
            rv_pkg::alu_xor:
            begin
                y = a ^ b;
            end
            rv_pkg::alu_srl:
            begin
                y = a >> shamt;
            end
            rv_pkg::alu_sra:
            begin
                y = $unsigned($signed(a) >>> shamt);
            end
            rv_pkg::alu_or:
            begin
                y = a | b;
            end
            default:
            begin
                y = a & b;
            end
        endcase
    end

endmodule

/* hw/axil_host_port.sv */
`timescale 1ns/1ns

module axil_host_port (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::axil_req_t req,
    output rv_pkg::axil_rsp_t rsp,
    output rv_pkg::instr_t    instr,
    input  logic              legal,
    output logic              wr_en,
    output rv_pkg::reg_addr_t dbg_addr,
    input  rv_pkg::word_t     dbg_data
);

    logic          b_pending;
    logic [1:0]    bresp_q;
    logic          r_pending;
    rv_pkg::word_t rdata_q;
    logic [1:0]    rresp_q;
    rv_pkg::word_t retired;

    logic aw_fire;
    logic ar_fire;
    logic is_instr_addr;
    logic is_reg_addr;
    logic is_retired_addr;

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////

    // Address and data are taken together, never while a response waits
    assign aw_fire       = req.awvalid & req.wvalid & ~b_pending;
    assign is_instr_addr = (req.awaddr == rv_pkg::addr_instr);
    assign wr_en         = aw_fire & is_instr_addr & legal;
    assign instr         = req.wdata;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            b_pending <= 1'b0;
            retired   <= '0;
        end
        else
        begin
            if (aw_fire)
            begin
                b_pending <= 1'b1;
            end
            else if (req.bready)
            begin
                b_pending <= 1'b0;
            end

            if (wr_en)
            begin
                retired <= retired + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (aw_fire)
        begin
            bresp_q <= wr_en ? rv_pkg::resp_okay : rv_pkg::resp_slverr;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////
    assign ar_fire  = req.arvalid & ~r_pending;
    assign dbg_addr = req.araddr[6:2];

    // Register window 0x080..0x0fc, word aligned
    assign is_reg_addr = (req.araddr[11:7] == rv_pkg::addr_reg_base[11:7])
                       && (req.araddr[1:0] == 2'b00);
    assign is_retired_addr = (req.araddr == rv_pkg::addr_retired);

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            r_pending <= 1'b0;
        end
        else if (ar_fire)
        begin
            r_pending <= 1'b1;
        end
        else if (req.rready)
        begin
            r_pending <= 1'b0;
        end
    end

    // Sampled before any same-cycle register write lands
    always_ff @(posedge clk)
    begin
        if (ar_fire)
        begin
            if (is_reg_addr)
            begin
                rdata_q <= dbg_data;
                rresp_q <= rv_pkg::resp_okay;
            end
            else if (is_retired_addr)
            begin
                rdata_q <= retired;
                rresp_q <= rv_pkg::resp_okay;
            end
            else
            begin
                rdata_q <= '0;
                rresp_q <= rv_pkg::resp_slverr;
            end
        end
    end

    always_comb
    begin
        rsp.awready = aw_fire;
        rsp.wready  = aw_fire;
        rsp.bresp   = bresp_q;
        rsp.bvalid  = b_pending;
        rsp.arready = ~r_pending;
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
        rsp.rvalid  = r_pending;
    end

endmodule

/* hw/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder (
    input  rv_pkg::instr_t     instr,
    output rv_pkg::exec_ctrl_t ctrl
);

    logic [6:0] imm_upper;

    // Upper seven bits of the I immediate, funct7 position for shifts
    assign imm_upper = instr.i.imm12[11:5];

    always_comb
    begin
        ctrl.rs1     = instr.r.rs1;
        ctrl.rs2     = instr.r.rs2;
        ctrl.rd      = instr.r.rd;
        ctrl.imm     = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        ctrl.alu_op  = rv_pkg::alu_add;
        ctrl.use_imm = 1'b0;
        ctrl.legal   = 1'b1;

        case (instr.r.opcode)
            rv_pkg::opcode_op:
            begin
                case (instr.r.funct3)
                    3'b000: ctrl.alu_op = (instr.r.funct7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
                    3'b001: ctrl.alu_op = rv_pkg::alu_sll;
                    3'b010: ctrl.alu_op = rv_pkg::alu_slt;
                    3'b011: ctrl.alu_op = rv_pkg::alu_sltu;
                    3'b100: ctrl.alu_op = rv_pkg::alu_xor;
                    3'b101: ctrl.alu_op = (instr.r.funct7[5]) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110: ctrl.alu_op = rv_pkg::alu_or;
                    default: ctrl.alu_op = rv_pkg::alu_and;
                endcase
                // Only sub and sra may carry 0x20
                if ((instr.r.funct3 == 3'b000) || (instr.r.funct3 == 3'b101))
                begin
                    ctrl.legal = (instr.r.funct7 == 7'h00) || (instr.r.funct7 == 7'h20);
                end
                else
                begin
                    ctrl.legal = (instr.r.funct7 == 7'h00);
                end
            end
            rv_pkg::opcode_op_imm:
            begin
                ctrl.use_imm = 1'b1;
                case (instr.i.funct3)
                    3'b000: ctrl.alu_op = rv_pkg::alu_add;
                    3'b010: ctrl.alu_op = rv_pkg::alu_slt;
                    3'b011: ctrl.alu_op = rv_pkg::alu_sltu;
                    3'b100: ctrl.alu_op = rv_pkg::alu_xor;
                    3'b110: ctrl.alu_op = rv_pkg::alu_or;
                    3'b111: ctrl.alu_op = rv_pkg::alu_and;
                    3'b001:
                    begin
                        ctrl.alu_op = rv_pkg::alu_sll;
                        ctrl.legal  = (imm_upper == 7'h00);
                    end
                    default:
                    begin
                        // Bit 30 picks srai over srli
                        ctrl.alu_op = (instr.i.imm12[10]) ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                        ctrl.legal  = ((imm_upper & 7'h5f) == 7'h00);
                    end
                endcase
            end
            default:
            begin
                ctrl.legal = 1'b0;
            end
        endcase
    end

endmodule

/* hw/register_file.sv */
`timescale 1ns/1ns

module register_file #(
    parameter rv_pkg::word_t stack_pointer_val = 32'd1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t dbg_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_data,
    input  logic              wr_en,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data,
    output rv_pkg::word_t     dbg_data
);

    // x2 is the stack pointer
    localparam int sp_index = 2;

    rv_pkg::word_t regs [rv_pkg::reg_count];

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < rv_pkg::reg_count; i++)
            begin
                regs[i] <= (i == sp_index) ? stack_pointer_val : '0;
            end
        end
        else if (wr_en && (rd_addr != '0))
        begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Register zero reads as zero on every port
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

/* hw/rv_exec_unit.sv */
`timescale 1ns/1ns

module rv_exec_unit #(
    parameter rv_pkg::word_t stack_pointer_val = 32'd1024
) (
    input  logic              clk,
    input  logic              arst_n,
    input  rv_pkg::axil_req_t req,
    output rv_pkg::axil_rsp_t rsp
);

    rv_pkg::instr_t     instr;
    rv_pkg::exec_ctrl_t ctrl;
    logic               wr_en;
    rv_pkg::reg_addr_t  dbg_addr;
    rv_pkg::word_t      dbg_data;
    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;
    rv_pkg::word_t      alu_b;
    rv_pkg::word_t      alu_y;

    axil_host_port u_host_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .rsp      (rsp),
        .instr    (instr),
        .legal    (ctrl.legal),
        .wr_en    (wr_en),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    instr_decoder u_decoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    register_file #(
        .stack_pointer_val (stack_pointer_val)
    ) u_regfile (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (ctrl.rs1),
        .rs2_addr (ctrl.rs2),
        .dbg_addr (dbg_addr),
        .rd_addr  (ctrl.rd),
        .rd_data  (alu_y),
        .wr_en    (wr_en),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dbg_data (dbg_data)
    );

    // Immediate replaces rs2 for op-imm
    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    alu u_alu (
        .op (ctrl.alu_op),
        .a  (rs1_data),
        .b  (alu_b),
        .y  (alu_y)
    );

endmodule

/* hw/rv_pkg.sv */
package rv_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and register file size
    ////////////////////////////////////////////////////////////
    localparam int xlen      = 32;
    localparam int reg_count = 32;

    typedef logic [4:0]        reg_addr_t;
    typedef logic [xlen - 1:0] word_t;

    ////////////////////////////////////////////////////////////
    // Instruction formats
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_addr_t   rs1;
        logic [2:0]  funct3;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // Same 32 bits, seen as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // Everything the datapath needs for one instruction
    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_e   alu_op;
        logic      use_imm;
        word_t     imm;
        logic      legal;
    } exec_ctrl_t;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite channels and address map
    ////////////////////////////////////////////////////////////
    typedef logic [11:0] axil_addr_t;

    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        word_t      wdata;
        logic [3:0] wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
        logic       arready;
        word_t      rdata;
        logic [1:0] rresp;
        logic       rvalid;
    } axil_rsp_t;

    localparam axil_addr_t addr_instr    = 12'h000;
    localparam axil_addr_t addr_retired  = 12'h004;
    localparam axil_addr_t addr_reg_base = 12'h080;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

endpackage

/* rv_exec_unit.f */
+incdir+test
hw/rv_pkg.sv
hw/register_file.sv
hw/instr_decoder.sv
hw/alu.sv
hw/axil_host_port.sv
hw/rv_exec_unit.sv
test/rv_exec_unit_tb.sv

/* test/rv_exec_ref.svh */
`ifndef rv_exec_ref_svh
`define rv_exec_ref_svh

// Instruction encoders for stimulus
function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
endfunction

// Only OP and OP-IMM with a valid upper field are accepted
function automatic bit is_legal_word(input logic [31:0] word);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] upper;
    opcode = word[6:0];
    funct3 = word[14:12];
    upper  = word[31:25];
    if (opcode == 7'b0110011)
    begin
        if (upper == 7'h00)
            return 1'b1;
        return (upper == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101));
    end
    if (opcode == 7'b0010011)
    begin
        if (funct3 == 3'b001)
            return upper == 7'h00;
        if (funct3 == 3'b101)
            return (upper == 7'h00) || (upper == 7'h20);
        return 1'b1;
    end
    return 1'b0;
endfunction

// Result of a legal word given the two source register values
function automatic logic [31:0] exec_result(input logic [31:0] word,
                                            input logic [31:0] rs1_val,
                                            input logic [31:0] rs2_val);
    logic [31:0] b;
    logic [4:0]  sh;
    b  = (word[6:0] == 7'b0010011) ? {{20{word[31]}}, word[31:20]} : rs2_val;
    sh = b[4:0];
    case (word[14:12])
        3'b000: return (word[30] && (word[6:0] == 7'b0110011)) ? rs1_val - b : rs1_val + b;
        3'b001: return rs1_val << sh;
        3'b010: return ($signed(rs1_val) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: return (rs1_val < b) ? 32'd1 : 32'd0;
        3'b100: return rs1_val ^ b;
        3'b101: return word[30] ? $unsigned($signed(rs1_val) >>> sh) : rs1_val >> sh;
        3'b110: return rs1_val | b;
        default: return rs1_val & b;
    endcase
endfunction

`endif

/* test/rv_exec_unit_tb.sv */
`timescale 1ns/1ns

module rv_exec_unit_tb;

    `include "rv_exec_ref.svh"

    localparam logic [31:0] sp_reset       = 32'd1024;
    // Room for about 600 transactions at an average of 10 cycles
    localparam int          txn_budget     = 600;
    localparam int          cycles_per_txn = 10;
    localparam int          cycle_limit    = txn_budget * cycles_per_txn;
    localparam int          wait_limit     = 32;

    logic              clk;
    logic              arst_n;
    rv_pkg::axil_req_t req;
    rv_pkg::axil_rsp_t rsp;

    logic [31:0] shadow [32];
    int          retired_model = 0;
    int          mismatch_count = 0;
    int          other_errors = 0;
    int          cycle_count = 0;
    integer      seed;

    logic [1:0]  exp_bresp [$];
    logic [31:0] exp_rdata [$];
    logic [1:0]  exp_rresp [$];

    rv_exec_unit #(
        .stack_pointer_val (sp_reset)
    ) rv_exec_unit_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
        begin
            $display("Run stopped at the cycle limit of %0d before all tests ended", cycle_limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("MISMATCH %s actual=%08h expected=%08h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    // Compare every completed response with the model's prediction
    always @(posedge clk)
    begin
        if (rsp.bvalid && req.bready)
        begin
            if (exp_bresp.size() == 0)
            begin
                $display("Write response arrived with no write outstanding");
                other_errors++;
            end
            else
                check_value("bresp", rsp.bresp, exp_bresp.pop_front());
        end
        if (rsp.rvalid && req.rready)
        begin
            if (exp_rdata.size() == 0)
            begin
                $display("Read data arrived with no read outstanding");
                other_errors++;
            end
            else
            begin
                check_value("rdata", rsp.rdata, exp_rdata.pop_front());
                check_value("rresp", rsp.rresp, exp_rresp.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Shadow model
    ////////////////////////////////////////////////////////////
    task automatic update_model(input logic [11:0] addr, input logic [31:0] word);
        logic [31:0] result;
        if ((addr == rv_pkg::addr_instr) && is_legal_word(word))
        begin
            result = exec_result(word, shadow[word[19:15]], shadow[word[24:20]]);
            if (word[11:7] != 5'd0)
                shadow[word[11:7]] = result;
            retired_model++;
            exp_bresp.push_back(rv_pkg::resp_okay);
        end
        else
            exp_bresp.push_back(rv_pkg::resp_slverr);
    endtask

    task automatic expect_read(input logic [11:0] addr);
        if ((addr[11:7] == 5'b00001) && (addr[1:0] == 2'b00))
        begin
            exp_rdata.push_back(shadow[addr[6:2]]);
            exp_rresp.push_back(rv_pkg::resp_okay);
        end
        else if (addr == rv_pkg::addr_retired)
        begin
            exp_rdata.push_back(retired_model);
            exp_rresp.push_back(rv_pkg::resp_okay);
        end
        else
        begin
            exp_rdata.push_back(32'd0);
            exp_rresp.push_back(rv_pkg::resp_slverr);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite driver
    ////////////////////////////////////////////////////////////
    function automatic bit rsp_flag(input string name);
        if (name == "awready")
            return rsp.awready;
        if (name == "bvalid")
            return rsp.bvalid;
        if (name == "arready")
            return rsp.arready;
        return rsp.rvalid;
    endfunction

    task automatic wait_flag(input string name, output bit seen);
        int waited;
        waited = 0;
        seen   = 1'b0;
        while (!seen && (waited < wait_limit))
        begin
            @(posedge clk);
            seen = rsp_flag(name);
            waited++;
        end
        if (!seen)
        begin
            $display("Handshake did not complete, %s never went high", name);
            other_errors++;
        end
    endtask

    // Response must stay valid and the request side closed while ready is held low
    task automatic hold_response(input string valid_name, input string ready_name,
                                 input int delay);
        repeat (delay)
        begin
            @(posedge clk);
            check_value(valid_name, rsp_flag(valid_name), 1);
            check_value(ready_name, rsp_flag(ready_name), 0);
        end
    endtask

    task automatic write_word(input logic [11:0] addr, input logic [31:0] word, input int delay);
        bit seen;
        update_model(addr, word);
        @(posedge clk);
        req.awaddr  <= addr;
        req.awvalid <= 1'b1;
        req.wdata   <= word;
        req.wstrb   <= 4'hf;
        req.wvalid  <= 1'b1;
        wait_flag("awready", seen);
        if (seen)
            check_value("wready", rsp.wready, 1'b1);
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        if (seen)
        begin
            wait_flag("bvalid", seen);
            if (seen)
            begin
                // The same write is offered again and must wait behind bvalid
                if (delay > 0)
                begin
                    req.awvalid <= 1'b1;
                    req.wvalid  <= 1'b1;
                end
                hold_response("bvalid", "awready", delay);
                req.awvalid <= 1'b0;
                req.wvalid  <= 1'b0;
                req.bready  <= 1'b1;
                @(posedge clk);
                req.bready <= 1'b0;
            end
        end
    endtask

    task automatic read_word(input logic [11:0] addr, input int delay);
        bit seen;
        expect_read(addr);
        @(posedge clk);
        req.araddr  <= addr;
        req.arvalid <= 1'b1;
        wait_flag("arready", seen);
        req.arvalid <= 1'b0;
        if (seen)
        begin
            wait_flag("rvalid", seen);
            if (seen)
            begin
                hold_response("rvalid", "arready", delay);
                req.rready <= 1'b1;
                @(posedge clk);
                req.rready <= 1'b0;
            end
        end
    endtask

    task automatic sweep_registers(input bit slow);
        int delay;
        for (int n = 0; n < 32; n++)
        begin
            delay = slow ? ($random(seed) & 7) : 0;
            read_word(rv_pkg::addr_reg_base + {5'd0, n[4:0], 2'b00}, delay);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        logic [31:0] rnd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        seed   = 32'h3d96;
        req    = '0;
        arst_n = 1'b0;
        for (int n = 0; n < 32; n++)
            shadow[n] = (n == 2) ? sp_reset : 32'd0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // Reset contents
        sweep_registers(1'b0);
        read_word(rv_pkg::addr_retired, 0);

        // Random values into x1..x31
        for (int n = 1; n < 32; n++)
        begin
            rnd = $random(seed);
            write_word(rv_pkg::addr_instr, i_word(rnd[11:0], 5'd0, 3'b000, n[4:0]), 0);
            write_word(rv_pkg::addr_instr, i_word({7'h00, rnd[16:12]}, n[4:0], 3'b001, n[4:0]), 0);
            write_word(rv_pkg::addr_instr, i_word(rnd[28:17], n[4:0], 3'b100, n[4:0]), 0);
        end

        for (int k = 0; k < 100; k++)
        begin
            rnd = $random(seed);
            f3  = rnd[2:0];
            f7  = (((f3 == 3'b000) || (f3 == 3'b101)) && rnd[3]) ? 7'h20 : 7'h00;
            write_word(rv_pkg::addr_instr, r_word(f7, rnd[8:4], rnd[13:9], f3, rnd[18:14]), 0);
        end
        sweep_registers(1'b0);

        // Every funct3 in turn with srli and srai alternating
        for (int k = 0; k < 100; k++)
        begin
            rnd = $random(seed);
            f3  = k[2:0];
            imm = rnd[11:0];
            if (f3 == 3'b001)
                imm = {7'h00, rnd[4:0]};
            if (f3 == 3'b101)
                imm = {1'b0, k[3], 5'h00, rnd[4:0]};
            write_word(rv_pkg::addr_instr, i_word(imm, rnd[16:12], f3, rnd[21:17]), 0);
        end
        sweep_registers(1'b0);

        // Writes to x0 retire but leave it at zero
        write_word(rv_pkg::addr_instr, i_word(12'h005, 5'd1, 3'b000, 5'd0), 0);
        write_word(rv_pkg::addr_instr, r_word(7'h20, 5'd3, 5'd1, 3'b000, 5'd0), 0);
        read_word(rv_pkg::addr_reg_base, 0);
        read_word(rv_pkg::addr_retired, 0);

        // Illegal words, foreign addresses, unmapped reads
        write_word(rv_pkg::addr_instr, {12'h010, 5'd1, 3'b010, 5'd3, 7'b0000011}, 0);
        write_word(rv_pkg::addr_instr, r_word(7'h01, 5'd2, 5'd1, 3'b000, 5'd3), 0);
        write_word(rv_pkg::addr_instr, r_word(7'h20, 5'd2, 5'd1, 3'b100, 5'd3), 0);
        write_word(rv_pkg::addr_instr, i_word(12'h201, 5'd1, 3'b101, 5'd4), 0);
        write_word(rv_pkg::addr_instr, i_word(12'h402, 5'd1, 3'b001, 5'd5), 0);
        write_word(12'h008, i_word(12'h123, 5'd0, 3'b000, 5'd6), 0);
        write_word(rv_pkg::addr_retired, i_word(12'h456, 5'd0, 3'b000, 5'd7), 0);
        read_word(12'h008, 0);
        read_word(12'h100, 0);
        read_word(12'h07c, 0);
        sweep_registers(1'b0);
        read_word(rv_pkg::addr_retired, 0);

        // Back-pressure on both response channels
        for (int k = 0; k < 20; k++)
        begin
            rnd = $random(seed);
            write_word(rv_pkg::addr_instr, r_word(7'h00, rnd[8:4], rnd[13:9], rnd[2:0],
                       rnd[18:14]), rnd[22:20]);
            read_word(rv_pkg::addr_reg_base + {5'd0, rnd[18:14], 2'b00}, rnd[26:24]);
        end
        sweep_registers(1'b1);
        read_word(rv_pkg::addr_retired, 3);

        repeat (4) @(posedge clk);
        if ((exp_bresp.size() != 0) || (exp_rdata.size() != 0))
        begin
            $display("Some expected responses were never received");
            other_errors++;
        end
        $display("Summary: %0d mismatches, %0d other errors, %0d instructions retired",
                 mismatch_count, other_errors, retired_model);
        if ((mismatch_count == 0) && (other_errors == 0))
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
